// ==== sources.f ====
hw/udp_switch_pkg.sv
hw/ip_rx_classifier.sv
hw/udp_rx_parser.sv
hw/udp_tx_framer.sv
hw/ip_tx_arbiter.sv
hw/udp_ip_switch.sv
tests/udp_ip_switch_asserts.sv
tests/udp_ip_switch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module udp_ip_switch_tb -f sources.f
./obj_dir/Vudp_ip_switch_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "Run passed"
else
  echo "Run failed"
  exit 1
fi

// ==== tests/udp_ip_switch_tb.sv ====
/* Drives all three input channels of the switch and checks all three outputs.
   Transmit frames are told apart on tx_ip by protocol, so raw frames use 6. */
`timescale 1ns/1ps

module udp_ip_switch_tb;
  import udp_switch_pkg::*;

  localparam int TOTAL_FRAMES = 48;
  localparam logic [7:0] PROTO_TCP = 8'd6;

  logic clk = 1'b0;
  logic rst;
  ip_hdr_t rx_ip_hdr, ip_out_hdr, ip_in_hdr, tx_ip_hdr;
  udp_hdr_t udp_out_hdr, udp_in_hdr;
  axis_beat_t rx_ip_beat, ip_out_beat, udp_out_beat, udp_in_beat, ip_in_beat, tx_ip_beat;
  logic rx_ip_hdr_valid, rx_ip_hdr_ready, rx_ip_beat_valid, rx_ip_beat_ready;
  logic ip_out_hdr_valid, ip_out_hdr_ready, ip_out_beat_valid, ip_out_beat_ready;
  logic udp_out_hdr_valid, udp_out_hdr_ready, udp_out_beat_valid, udp_out_beat_ready;
  logic udp_in_hdr_valid, udp_in_hdr_ready, udp_in_beat_valid, udp_in_beat_ready;
  logic ip_in_hdr_valid, ip_in_hdr_ready, ip_in_beat_valid, ip_in_beat_ready;
  logic tx_ip_hdr_valid, tx_ip_hdr_ready, tx_ip_beat_valid, tx_ip_beat_ready;

  // Expected traffic per output path
  ip_hdr_t    exp_ipo_hdr[$];
  axis_beat_t exp_ipo_beat[$];
  udp_hdr_t   exp_udp_hdr[$];
  axis_beat_t exp_udp_beat[$];
  ip_hdr_t    exp_txu_hdr[$];
  axis_beat_t exp_txu_beat[$];
  ip_hdr_t    exp_txr_hdr[$];
  axis_beat_t exp_txr_beat[$];
  logic [7:0] tx_seen[$];

  int   errors = 0;
  int   tests_run = 0;
  int   test_start_errors;
  bit   rand_ready = 1'b0;
  bit   gaps = 1'b0;
  logic tx_cur_udp = 1'b0;

  udp_ip_switch udp_ip_switch_inst (.*);

  always #5 clk = ~clk;

  function automatic udp_hdr_t expect_udp_hdr(input ip_hdr_t ih, input axis_beat_t b);
    udp_hdr_t u;
    logic [7:0] by [8];
    for (int i = 0; i < 8; i++) by[i] = b.data[8*i +: 8];
    u.ip_dscp      = ih.dscp;
    u.ip_ecn       = ih.ecn;
    u.ip_ttl       = ih.ttl;
    u.ip_source_ip = ih.source_ip;
    u.ip_dest_ip   = ih.dest_ip;
    u.source_port  = {by[0], by[1]};
    u.dest_port    = {by[2], by[3]};
    u.length       = {by[4], by[5]};
    u.checksum     = {by[6], by[7]};
    return u;
  endfunction

  function automatic ip_hdr_t expect_tx_hdr(input udp_hdr_t u);
    ip_hdr_t h;
    h.dscp      = u.ip_dscp;
    h.ecn       = u.ip_ecn;
    h.length    = u.length + 16'd20;
    h.ttl       = u.ip_ttl;
    h.protocol  = PROTO_UDP;
    h.source_ip = u.ip_source_ip;
    h.dest_ip   = u.ip_dest_ip;
    return h;
  endfunction

  function automatic axis_beat_t expect_hdr_beat(input udp_hdr_t u);
    axis_beat_t b;
    logic [7:0] by [8];
    by[0] = u.source_port[15:8];
    by[1] = u.source_port[7:0];
    by[2] = u.dest_port[15:8];
    by[3] = u.dest_port[7:0];
    by[4] = u.length[15:8];
    by[5] = u.length[7:0];
    by[6] = u.checksum[15:8];
    by[7] = u.checksum[7:0];
    for (int i = 0; i < 8; i++) b.data[8*i +: 8] = by[i];
    b.keep = 8'hff;
    b.last = 1'b0;
    b.user = 1'b0;
    return b;
  endfunction

  function automatic axis_beat_t rand_beat(input bit last);
    axis_beat_t b;
    b.data = {$urandom, $urandom};
    b.keep = last ? (8'hff >> ($urandom % 8)) : 8'hff;
    b.last = last;
    b.user = 1'($urandom);
    return b;
  endfunction

  function automatic ip_hdr_t rand_ip_hdr(input logic [7:0] proto);
    ip_hdr_t h;
    h.dscp      = 6'($urandom);
    h.ecn       = 2'($urandom);
    h.length    = 16'($urandom);
    h.ttl       = 8'($urandom);
    h.protocol  = proto;
    h.source_ip = $urandom;
    h.dest_ip   = $urandom;
    return h;
  endfunction

  task automatic check(input string name, input logic [143:0] got, input logic [143:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic unexpected(input string name);
    $display("Unexpected transfer on %s with nothing left to expect", name);
    errors++;
  endtask

  task automatic idle_gap();
    if (gaps) repeat ($urandom % 3) @(negedge clk);
  endtask

  // Each send starts on a falling edge and returns on the one after the transfer
  task automatic send_rx(input ip_hdr_t h, input axis_beat_t beats[$]);
    logic ok;
    idle_gap();
    rx_ip_hdr = h;
    rx_ip_hdr_valid = 1'b1;
    forever begin
      #1 ok = rx_ip_hdr_ready;
      @(negedge clk);
      if (ok) break;
    end
    rx_ip_hdr_valid = 1'b0;
    foreach (beats[i]) begin
      idle_gap();
      rx_ip_beat = beats[i];
      rx_ip_beat_valid = 1'b1;
      forever begin
        #1 ok = rx_ip_beat_ready;
        @(negedge clk);
        if (ok) break;
      end
      rx_ip_beat_valid = 1'b0;
    end
  endtask

  task automatic send_udp(input udp_hdr_t h, input axis_beat_t beats[$]);
    logic ok;
    idle_gap();
    udp_in_hdr = h;
    udp_in_hdr_valid = 1'b1;
    forever begin
      #1 ok = udp_in_hdr_ready;
      @(negedge clk);
      if (ok) break;
    end
    udp_in_hdr_valid = 1'b0;
    foreach (beats[i]) begin
      idle_gap();
      udp_in_beat = beats[i];
      udp_in_beat_valid = 1'b1;
      forever begin
        #1 ok = udp_in_beat_ready;
        @(negedge clk);
        if (ok) break;
      end
      udp_in_beat_valid = 1'b0;
    end
  endtask

  task automatic send_raw(input ip_hdr_t h, input axis_beat_t beats[$]);
    logic ok;
    idle_gap();
    ip_in_hdr = h;
    ip_in_hdr_valid = 1'b1;
    forever begin
      #1 ok = ip_in_hdr_ready;
      @(negedge clk);
      if (ok) break;
    end
    ip_in_hdr_valid = 1'b0;
    foreach (beats[i]) begin
      idle_gap();
      ip_in_beat = beats[i];
      ip_in_beat_valid = 1'b1;
      forever begin
        #1 ok = ip_in_beat_ready;
        @(negedge clk);
        if (ok) break;
      end
      ip_in_beat_valid = 1'b0;
    end
  endtask

  task automatic rx_frame(input bit is_udp, input int nbeats);
    ip_hdr_t    h;
    axis_beat_t beats[$];
    h = rand_ip_hdr(is_udp ? PROTO_UDP : PROTO_TCP);
    for (int i = 0; i < nbeats; i++) beats.push_back(rand_beat(i == nbeats - 1));
    if (is_udp) begin
      // Parser needs the whole UDP header in the first beat
      beats[0].keep = 8'hff;
      exp_udp_hdr.push_back(expect_udp_hdr(h, beats[0]));
      for (int i = 1; i < nbeats; i++) exp_udp_beat.push_back(beats[i]);
    end else begin
      exp_ipo_hdr.push_back(h);
      foreach (beats[i]) exp_ipo_beat.push_back(beats[i]);
    end
    send_rx(h, beats);
  endtask

  task automatic udp_frame(input int nbeats);
    udp_hdr_t   u;
    axis_beat_t beats[$];
    u = {$urandom, $urandom, $urandom, $urandom, 16'($urandom)};
    for (int i = 0; i < nbeats; i++) beats.push_back(rand_beat(i == nbeats - 1));
    exp_txu_hdr.push_back(expect_tx_hdr(u));
    exp_txu_beat.push_back(expect_hdr_beat(u));
    foreach (beats[i]) exp_txu_beat.push_back(beats[i]);
    send_udp(u, beats);
  endtask

  task automatic raw_frame(input int nbeats);
    ip_hdr_t    h;
    axis_beat_t beats[$];
    h = rand_ip_hdr(PROTO_TCP);
    for (int i = 0; i < nbeats; i++) beats.push_back(rand_beat(i == nbeats - 1));
    exp_txr_hdr.push_back(h);
    foreach (beats[i]) exp_txr_beat.push_back(beats[i]);
    send_raw(h, beats);
  endtask

  task automatic end_test(input string name);
    while (exp_ipo_hdr.size() + exp_ipo_beat.size() + exp_udp_hdr.size() +
           exp_udp_beat.size() + exp_txu_hdr.size() + exp_txu_beat.size() +
           exp_txr_hdr.size() + exp_txr_beat.size() > 0) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);
    tests_run++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (errors == test_start_errors) ? "ok" : "failed", errors - test_start_errors);
    test_start_errors = errors;
  endtask

  always @(negedge clk) begin
    if (rand_ready) begin
      ip_out_hdr_ready   = ($urandom % 4) != 0;
      ip_out_beat_ready  = ($urandom % 4) != 0;
      udp_out_hdr_ready  = ($urandom % 4) != 0;
      udp_out_beat_ready = ($urandom % 4) != 0;
      tx_ip_hdr_ready    = ($urandom % 4) != 0;
      tx_ip_beat_ready   = ($urandom % 4) != 0;
    end else begin
      {ip_out_hdr_ready, ip_out_beat_ready, udp_out_hdr_ready} = 3'b111;
      {udp_out_beat_ready, tx_ip_hdr_ready, tx_ip_beat_ready} = 3'b111;
    end
  end

  // Compare every accepted output transfer with the expected queues
  always @(posedge clk) begin
    if (!rst) begin
      if (ip_out_hdr_valid && ip_out_hdr_ready) begin
        if (exp_ipo_hdr.size() == 0) unexpected("ip_out_hdr");
        else check("ip_out_hdr", 144'(ip_out_hdr), 144'(exp_ipo_hdr.pop_front()));
      end
      if (ip_out_beat_valid && ip_out_beat_ready) begin
        if (exp_ipo_beat.size() == 0) unexpected("ip_out_beat");
        else check("ip_out_beat", 144'(ip_out_beat), 144'(exp_ipo_beat.pop_front()));
      end
      if (udp_out_hdr_valid && udp_out_hdr_ready) begin
        if (exp_udp_hdr.size() == 0) unexpected("udp_out_hdr");
        else check("udp_out_hdr", udp_out_hdr, exp_udp_hdr.pop_front());
      end
      if (udp_out_beat_valid && udp_out_beat_ready) begin
        if (exp_udp_beat.size() == 0) unexpected("udp_out_beat");
        else check("udp_out_beat", 144'(udp_out_beat), 144'(exp_udp_beat.pop_front()));
      end
      if (tx_ip_hdr_valid && tx_ip_hdr_ready) begin
        tx_seen.push_back(tx_ip_hdr.protocol);
        tx_cur_udp = (tx_ip_hdr.protocol == PROTO_UDP);
        if (tx_cur_udp && exp_txu_hdr.size() != 0)
          check("tx_ip_hdr", 144'(tx_ip_hdr), 144'(exp_txu_hdr.pop_front()));
        else if (!tx_cur_udp && exp_txr_hdr.size() != 0)
          check("tx_ip_hdr", 144'(tx_ip_hdr), 144'(exp_txr_hdr.pop_front()));
        else
          unexpected("tx_ip_hdr");
      end
      if (tx_ip_beat_valid && tx_ip_beat_ready) begin
        if (tx_cur_udp && exp_txu_beat.size() != 0)
          check("tx_ip_beat", 144'(tx_ip_beat), 144'(exp_txu_beat.pop_front()));
        else if (!tx_cur_udp && exp_txr_beat.size() != 0)
          check("tx_ip_beat", 144'(tx_ip_beat), 144'(exp_txr_beat.pop_front()));
        else
          unexpected("tx_ip_beat");
      end
    end
  end

  initial begin
    repeat (200 * TOTAL_FRAMES + 10) @(posedge clk);
    $display("The run timed out before all frames came out");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h8620_2131));
    rst = 1'b1;
    {rx_ip_hdr, ip_in_hdr} = '0;
    udp_in_hdr = '0;
    {rx_ip_beat, udp_in_beat, ip_in_beat} = '0;
    {rx_ip_hdr_valid, rx_ip_beat_valid, udp_in_hdr_valid} = 3'b000;
    {udp_in_beat_valid, ip_in_hdr_valid, ip_in_beat_valid} = 3'b000;
    {ip_out_hdr_ready, ip_out_beat_ready, udp_out_hdr_ready} = 3'b000;
    {udp_out_beat_ready, tx_ip_hdr_ready, tx_ip_beat_ready} = 3'b000;
    test_start_errors = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    rx_frame(1'b1, 3);
    rx_frame(1'b1, 1);
    end_test("udp receive");
    rx_frame(1'b0, 2);
    end_test("raw receive");
    udp_frame(2);
    udp_frame(1);
    end_test("udp transmit");
    raw_frame(3);
    end_test("raw transmit");

    // Raw header offered as the framer header reaches the idle arbiter
    tx_seen.delete();
    fork
      udp_frame(2);
      begin
        @(negedge clk);
        raw_frame(2);
      end
    join
    // Both frames have fully left the arbiter once their inputs are drained
    if (tx_seen.size() < 2 || tx_seen[0] != PROTO_UDP) begin
      $display("UDP frame did not leave the arbiter first");
      errors++;
    end
    end_test("priority");

    rand_ready = 1'b1;
    gaps = 1'b1;
    fork
      for (int i = 0; i < 16; i++) rx_frame(1'($urandom), 1 + int'($urandom % 4));
      for (int i = 0; i < 12; i++) udp_frame(1 + int'($urandom % 4));
      for (int i = 0; i < 12; i++) raw_frame(1 + int'($urandom % 4));
    join
    end_test("random mix");

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/udp_ip_switch_asserts.sv ====
/* Handshake checks on the three output channels of the switch */
`timescale 1ns/1ps

module udp_ip_switch_asserts (
  input logic                       clk,
  input logic                       rst,
  input udp_switch_pkg::ip_hdr_t    ip_out_hdr,
  input logic                       ip_out_hdr_valid,
  input logic                       ip_out_hdr_ready,
  input udp_switch_pkg::axis_beat_t ip_out_beat,
  input logic                       ip_out_beat_valid,
  input logic                       ip_out_beat_ready,
  input udp_switch_pkg::udp_hdr_t   udp_out_hdr,
  input logic                       udp_out_hdr_valid,
  input logic                       udp_out_hdr_ready,
  input udp_switch_pkg::axis_beat_t udp_out_beat,
  input logic                       udp_out_beat_valid,
  input logic                       udp_out_beat_ready,
  input udp_switch_pkg::ip_hdr_t    tx_ip_hdr,
  input logic                       tx_ip_hdr_valid,
  input logic                       tx_ip_hdr_ready,
  input udp_switch_pkg::axis_beat_t tx_ip_beat,
  input logic                       tx_ip_beat_valid,
  input logic                       tx_ip_beat_ready
);

  // Held valid keeps its data until taken
  assert property (@(posedge clk) disable iff (rst) ip_out_hdr_valid && !ip_out_hdr_ready
    |=> ip_out_hdr_valid && $stable(ip_out_hdr)) else $error("ip_out_hdr dropped");
  assert property (@(posedge clk) disable iff (rst) ip_out_beat_valid && !ip_out_beat_ready
    |=> ip_out_beat_valid && $stable(ip_out_beat)) else $error("ip_out_beat dropped");
  assert property (@(posedge clk) disable iff (rst) udp_out_hdr_valid && !udp_out_hdr_ready
    |=> udp_out_hdr_valid && $stable(udp_out_hdr)) else $error("udp_out_hdr dropped");
  assert property (@(posedge clk) disable iff (rst) udp_out_beat_valid && !udp_out_beat_ready
    |=> udp_out_beat_valid && $stable(udp_out_beat)) else $error("udp_out_beat dropped");
  assert property (@(posedge clk) disable iff (rst) tx_ip_hdr_valid && !tx_ip_hdr_ready
    |=> tx_ip_hdr_valid && $stable(tx_ip_hdr)) else $error("tx_ip_hdr dropped");
  assert property (@(posedge clk) disable iff (rst) tx_ip_beat_valid && !tx_ip_beat_ready
    |=> tx_ip_beat_valid && $stable(tx_ip_beat)) else $error("tx_ip_beat dropped");

  assert property (@(posedge clk) rst && $past(rst) |-> !ip_out_hdr_valid && !ip_out_beat_valid
    && !udp_out_hdr_valid && !udp_out_beat_valid && !tx_ip_hdr_valid && !tx_ip_beat_valid)
    else $error("valid high during reset");

endmodule

bind udp_ip_switch udp_ip_switch_asserts udp_ip_switch_asserts_inst (
  .clk                (clk),
  .rst                (rst),
  .ip_out_hdr         (ip_out_hdr),
  .ip_out_hdr_valid   (ip_out_hdr_valid),
  .ip_out_hdr_ready   (ip_out_hdr_ready),
  .ip_out_beat        (ip_out_beat),
  .ip_out_beat_valid  (ip_out_beat_valid),
  .ip_out_beat_ready  (ip_out_beat_ready),
  .udp_out_hdr        (udp_out_hdr),
  .udp_out_hdr_valid  (udp_out_hdr_valid),
  .udp_out_hdr_ready  (udp_out_hdr_ready),
  .udp_out_beat       (udp_out_beat),
  .udp_out_beat_valid (udp_out_beat_valid),
  .udp_out_beat_ready (udp_out_beat_ready),
  .tx_ip_hdr          (tx_ip_hdr),
  .tx_ip_hdr_valid    (tx_ip_hdr_valid),
  .tx_ip_hdr_ready    (tx_ip_hdr_ready),
  .tx_ip_beat         (tx_ip_beat),
  .tx_ip_beat_valid   (tx_ip_beat_valid),
  .tx_ip_beat_ready   (tx_ip_beat_ready)
);

// ==== hw/udp_ip_switch.sv ====
/* Protocol switch between an IP stack and its users. On transmit the framer
   header reaches the arbiter one cycle after udp_in is accepted, so a raw
   frame offered on ip_in in that same cycle can still win the arbiter. */
`timescale 1ns/1ps

module udp_ip_switch (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_switch_pkg::ip_hdr_t    rx_ip_hdr,
  input  logic                       rx_ip_hdr_valid,
  output logic                       rx_ip_hdr_ready,
  input  udp_switch_pkg::axis_beat_t rx_ip_beat,
  input  logic                       rx_ip_beat_valid,
  output logic                       rx_ip_beat_ready,
  output udp_switch_pkg::ip_hdr_t    ip_out_hdr,
  output logic                       ip_out_hdr_valid,
  input  logic                       ip_out_hdr_ready,
  output udp_switch_pkg::axis_beat_t ip_out_beat,
  output logic                       ip_out_beat_valid,
  input  logic                       ip_out_beat_ready,
  output udp_switch_pkg::udp_hdr_t   udp_out_hdr,
  output logic                       udp_out_hdr_valid,
  input  logic                       udp_out_hdr_ready,
  output udp_switch_pkg::axis_beat_t udp_out_beat,
  output logic                       udp_out_beat_valid,
  input  logic                       udp_out_beat_ready,
  input  udp_switch_pkg::udp_hdr_t   udp_in_hdr,
  input  logic                       udp_in_hdr_valid,
  output logic                       udp_in_hdr_ready,
  input  udp_switch_pkg::axis_beat_t udp_in_beat,
  input  logic                       udp_in_beat_valid,
  output logic                       udp_in_beat_ready,
  input  udp_switch_pkg::ip_hdr_t    ip_in_hdr,
  input  logic                       ip_in_hdr_valid,
  output logic                       ip_in_hdr_ready,
  input  udp_switch_pkg::axis_beat_t ip_in_beat,
  input  logic                       ip_in_beat_valid,
  output logic                       ip_in_beat_ready,
  output udp_switch_pkg::ip_hdr_t    tx_ip_hdr,
  output logic                       tx_ip_hdr_valid,
  input  logic                       tx_ip_hdr_ready,
  output udp_switch_pkg::axis_beat_t tx_ip_beat,
  output logic                       tx_ip_beat_valid,
  input  logic                       tx_ip_beat_ready
);
  import udp_switch_pkg::*;

  // Classifier to parser
  ip_hdr_t    cls_hdr;
  logic       cls_hdr_valid;
  logic       cls_hdr_ready;
  axis_beat_t cls_beat;
  logic       cls_beat_valid;
  logic       cls_beat_ready;

  // Framer to arbiter input 0
  ip_hdr_t    frm_hdr;
  logic       frm_hdr_valid;
  logic       frm_hdr_ready;
  axis_beat_t frm_beat;
  logic       frm_beat_valid;
  logic       frm_beat_ready;

  ip_rx_classifier ip_rx_classifier_inst (
    .clk            (clk),
    .rst            (rst),
    .s_hdr          (rx_ip_hdr),
    .s_hdr_valid    (rx_ip_hdr_valid),
    .s_hdr_ready    (rx_ip_hdr_ready),
    .s_beat         (rx_ip_beat),
    .s_beat_valid   (rx_ip_beat_valid),
    .s_beat_ready   (rx_ip_beat_ready),
    .udp_hdr        (cls_hdr),
    .udp_hdr_valid  (cls_hdr_valid),
    .udp_hdr_ready  (cls_hdr_ready),
    .udp_beat       (cls_beat),
    .udp_beat_valid (cls_beat_valid),
    .udp_beat_ready (cls_beat_ready),
    .ip_hdr         (ip_out_hdr),
    .ip_hdr_valid   (ip_out_hdr_valid),
    .ip_hdr_ready   (ip_out_hdr_ready),
    .ip_beat        (ip_out_beat),
    .ip_beat_valid  (ip_out_beat_valid),
    .ip_beat_ready  (ip_out_beat_ready)
  );

  udp_rx_parser udp_rx_parser_inst (
    .clk          (clk),
    .rst          (rst),
    .s_hdr        (cls_hdr),
    .s_hdr_valid  (cls_hdr_valid),
    .s_hdr_ready  (cls_hdr_ready),
    .s_beat       (cls_beat),
    .s_beat_valid (cls_beat_valid),
    .s_beat_ready (cls_beat_ready),
    .m_hdr        (udp_out_hdr),
    .m_hdr_valid  (udp_out_hdr_valid),
    .m_hdr_ready  (udp_out_hdr_ready),
    .m_beat       (udp_out_beat),
    .m_beat_valid (udp_out_beat_valid),
    .m_beat_ready (udp_out_beat_ready)
  );

  udp_tx_framer udp_tx_framer_inst (
    .clk          (clk),
    .rst          (rst),
    .s_hdr        (udp_in_hdr),
    .s_hdr_valid  (udp_in_hdr_valid),
    .s_hdr_ready  (udp_in_hdr_ready),
    .s_beat       (udp_in_beat),
    .s_beat_valid (udp_in_beat_valid),
    .s_beat_ready (udp_in_beat_ready),
    .m_hdr        (frm_hdr),
    .m_hdr_valid  (frm_hdr_valid),
    .m_hdr_ready  (frm_hdr_ready),
    .m_beat       (frm_beat),
    .m_beat_valid (frm_beat_valid),
    .m_beat_ready (frm_beat_ready)
  );

  // UDP traffic on input 0 takes priority
  ip_tx_arbiter ip_tx_arbiter_inst (
    .clk           (clk),
    .rst           (rst),
    .s0_hdr        (frm_hdr),
    .s0_hdr_valid  (frm_hdr_valid),
    .s0_hdr_ready  (frm_hdr_ready),
    .s0_beat       (frm_beat),
    .s0_beat_valid (frm_beat_valid),
    .s0_beat_ready (frm_beat_ready),
    .s1_hdr        (ip_in_hdr),
    .s1_hdr_valid  (ip_in_hdr_valid),
    .s1_hdr_ready  (ip_in_hdr_ready),
    .s1_beat       (ip_in_beat),
    .s1_beat_valid (ip_in_beat_valid),
    .s1_beat_ready (ip_in_beat_ready),
    .m_hdr         (tx_ip_hdr),
    .m_hdr_valid   (tx_ip_hdr_valid),
    .m_hdr_ready   (tx_ip_hdr_ready),
    .m_beat        (tx_ip_beat),
    .m_beat_valid  (tx_ip_beat_valid),
    .m_beat_ready  (tx_ip_beat_ready)
  );

endmodule

// ==== hw/ip_tx_arbiter.sv ====
/* Two-input frame arbiter, s0 has priority. The grant is registered, so a
   frame starts one cycle after its header shows up at an idle arbiter. */
`timescale 1ns/1ps

module ip_tx_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_switch_pkg::ip_hdr_t    s0_hdr,
  input  logic                       s0_hdr_valid,
  output logic                       s0_hdr_ready,
  input  udp_switch_pkg::axis_beat_t s0_beat,
  input  logic                       s0_beat_valid,
  output logic                       s0_beat_ready,
  input  udp_switch_pkg::ip_hdr_t    s1_hdr,
  input  logic                       s1_hdr_valid,
  output logic                       s1_hdr_ready,
  input  udp_switch_pkg::axis_beat_t s1_beat,
  input  logic                       s1_beat_valid,
  output logic                       s1_beat_ready,
  output udp_switch_pkg::ip_hdr_t    m_hdr,
  output logic                       m_hdr_valid,
  input  logic                       m_hdr_ready,
  output udp_switch_pkg::axis_beat_t m_beat,
  output logic                       m_beat_valid,
  input  logic                       m_beat_ready
);
  logic busy;
  logic grant;
  logic hdr_sent;
  logic hdr_phase;
  logic beat_phase;

  assign hdr_phase  = busy && !hdr_sent;
  assign beat_phase = busy && hdr_sent;

  assign m_hdr        = grant ? s1_hdr : s0_hdr;
  assign m_hdr_valid  = hdr_phase && (grant ? s1_hdr_valid : s0_hdr_valid);
  assign s0_hdr_ready = hdr_phase && !grant && m_hdr_ready;
  assign s1_hdr_ready = hdr_phase && grant && m_hdr_ready;

  // Beats only after the granted header has gone out
  assign m_beat        = grant ? s1_beat : s0_beat;
  assign m_beat_valid  = beat_phase && (grant ? s1_beat_valid : s0_beat_valid);
  assign s0_beat_ready = beat_phase && !grant && m_beat_ready;
  assign s1_beat_ready = beat_phase && grant && m_beat_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      grant    <= 1'b0;
      hdr_sent <= 1'b0;
    end else if (!busy) begin
      if (s0_hdr_valid || s1_hdr_valid) begin
        busy     <= 1'b1;
        grant    <= !s0_hdr_valid;
        hdr_sent <= 1'b0;
      end
    end else begin
      if (m_hdr_valid && m_hdr_ready) begin
        hdr_sent <= 1'b1;
      end
      if (m_beat_valid && m_beat_ready && m_beat.last) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/udp_tx_framer.sv ====
/* Wraps a UDP datagram in an IP frame. The checksum is passed through as
   given, and the user payload must carry at least one beat. */
`timescale 1ns/1ps

module udp_tx_framer (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_switch_pkg::udp_hdr_t   s_hdr,
  input  logic                       s_hdr_valid,
  output logic                       s_hdr_ready,
  input  udp_switch_pkg::axis_beat_t s_beat,
  input  logic                       s_beat_valid,
  output logic                       s_beat_ready,
  output udp_switch_pkg::ip_hdr_t    m_hdr,
  output logic                       m_hdr_valid,
  input  logic                       m_hdr_ready,
  output udp_switch_pkg::axis_beat_t m_beat,
  output logic                       m_beat_valid,
  input  logic                       m_beat_ready
);
  import udp_switch_pkg::*;

  tx_state_t  state;
  udp_hdr_t   hdr_reg;
  logic       ip_hdr_pending;
  axis_beat_t hdr_beat;

  always_comb begin
    m_hdr.dscp      = hdr_reg.ip_dscp;
    m_hdr.ecn       = hdr_reg.ip_ecn;
    m_hdr.length    = hdr_reg.length + IP_HDR_BYTES;
    m_hdr.ttl       = hdr_reg.ip_ttl;
    m_hdr.protocol  = PROTO_UDP;
    m_hdr.source_ip = hdr_reg.ip_source_ip;
    m_hdr.dest_ip   = hdr_reg.ip_dest_ip;
  end

  // UDP header as the first payload beat, high byte of each field first
  assign hdr_beat.data = {hdr_reg.checksum[7:0], hdr_reg.checksum[15:8],
                          hdr_reg.length[7:0], hdr_reg.length[15:8],
                          hdr_reg.dest_port[7:0], hdr_reg.dest_port[15:8],
                          hdr_reg.source_port[7:0], hdr_reg.source_port[15:8]};
  assign hdr_beat.keep = keep_t'((1 << UDP_HDR_BYTES) - 1);
  assign hdr_beat.last = 1'b0;
  assign hdr_beat.user = 1'b0;

  assign s_hdr_ready  = (state == TX_IDLE);
  assign m_hdr_valid  = ip_hdr_pending;
  assign m_beat       = (state == TX_PAYLOAD) ? s_beat : hdr_beat;
  assign m_beat_valid = (state == TX_HDR_BEAT && !ip_hdr_pending) ||
                        (state == TX_PAYLOAD && s_beat_valid);
  assign s_beat_ready = (state == TX_PAYLOAD) && m_beat_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= TX_IDLE;
      ip_hdr_pending <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (s_hdr_valid) begin
            ip_hdr_pending <= 1'b1;
            state          <= TX_HDR_BEAT;
          end
        end
        TX_HDR_BEAT: begin
          if (ip_hdr_pending) begin
            if (m_hdr_ready) begin
              ip_hdr_pending <= 1'b0;
            end
          end else if (m_beat_ready) begin
            state <= TX_PAYLOAD;
          end
        end
        TX_PAYLOAD: begin
          if (s_beat_valid && m_beat_ready && s_beat.last) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && s_hdr_valid) begin
      hdr_reg <= s_hdr;
    end
  end

endmodule

// ==== hw/udp_rx_parser.sv ====
/* Pulls the 8-byte UDP header out of the first payload beat. That beat
   must hold the whole header; its user bit is not carried forward. */
`timescale 1ns/1ps

module udp_rx_parser (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_switch_pkg::ip_hdr_t    s_hdr,
  input  logic                       s_hdr_valid,
  output logic                       s_hdr_ready,
  input  udp_switch_pkg::axis_beat_t s_beat,
  input  logic                       s_beat_valid,
  output logic                       s_beat_ready,
  output udp_switch_pkg::udp_hdr_t   m_hdr,
  output logic                       m_hdr_valid,
  input  logic                       m_hdr_ready,
  output udp_switch_pkg::axis_beat_t m_beat,
  output logic                       m_beat_valid,
  input  logic                       m_beat_ready
);
  import udp_switch_pkg::*;

  rx_state_t state;
  udp_hdr_t  hdr_reg;
  logic      first_last;

  assign s_hdr_ready  = (state == RX_IDLE);
  assign s_beat_ready = (state == RX_WAIT_BEAT) || (state == RX_PAYLOAD && m_beat_ready);

  assign m_hdr       = hdr_reg;
  assign m_hdr_valid = (state == RX_HDR_OUT);

  // Remaining beats pass through untouched
  assign m_beat       = s_beat;
  assign m_beat_valid = (state == RX_PAYLOAD) && s_beat_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RX_IDLE;
      first_last <= 1'b0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (s_hdr_valid) begin
            state <= RX_WAIT_BEAT;
          end
        end
        RX_WAIT_BEAT: begin
          if (s_beat_valid) begin
            first_last <= s_beat.last;
            state      <= RX_HDR_OUT;
          end
        end
        RX_HDR_OUT: begin
          if (m_hdr_ready) begin
            state <= first_last ? RX_IDLE : RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          if (s_beat_valid && m_beat_ready && s_beat.last) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Fields arrive big-endian, first byte in lane 0
  always_ff @(posedge clk) begin
    if (state == RX_IDLE && s_hdr_valid) begin
      hdr_reg.ip_dscp      <= s_hdr.dscp;
      hdr_reg.ip_ecn       <= s_hdr.ecn;
      hdr_reg.ip_ttl       <= s_hdr.ttl;
      hdr_reg.ip_source_ip <= s_hdr.source_ip;
      hdr_reg.ip_dest_ip   <= s_hdr.dest_ip;
    end
    if (state == RX_WAIT_BEAT && s_beat_valid) begin
      hdr_reg.source_port <= {s_beat.data[7:0], s_beat.data[15:8]};
      hdr_reg.dest_port   <= {s_beat.data[23:16], s_beat.data[31:24]};
      hdr_reg.length      <= {s_beat.data[39:32], s_beat.data[47:40]};
      hdr_reg.checksum    <= {s_beat.data[55:48], s_beat.data[63:56]};
    end
  end

endmodule

// ==== hw/ip_rx_classifier.sv ====
/* Zero-latency protocol demux. The route is latched on header transfer
   and held until the last payload beat, so only one frame is in flight. */
`timescale 1ns/1ps

module ip_rx_classifier (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_switch_pkg::ip_hdr_t    s_hdr,
  input  logic                       s_hdr_valid,
  output logic                       s_hdr_ready,
  input  udp_switch_pkg::axis_beat_t s_beat,
  input  logic                       s_beat_valid,
  output logic                       s_beat_ready,
  output udp_switch_pkg::ip_hdr_t    udp_hdr,
  output logic                       udp_hdr_valid,
  input  logic                       udp_hdr_ready,
  output udp_switch_pkg::axis_beat_t udp_beat,
  output logic                       udp_beat_valid,
  input  logic                       udp_beat_ready,
  output udp_switch_pkg::ip_hdr_t    ip_hdr,
  output logic                       ip_hdr_valid,
  input  logic                       ip_hdr_ready,
  output udp_switch_pkg::axis_beat_t ip_beat,
  output logic                       ip_beat_valid,
  input  logic                       ip_beat_ready
);
  import udp_switch_pkg::*;

  logic sel_udp;
  logic route_active;
  logic route_udp;

  assign sel_udp = (s_hdr.protocol == PROTO_UDP);

  // Header steered straight through while no route is held
  assign udp_hdr       = s_hdr;
  assign ip_hdr        = s_hdr;
  assign udp_hdr_valid = s_hdr_valid && !route_active && sel_udp;
  assign ip_hdr_valid  = s_hdr_valid && !route_active && !sel_udp;
  assign s_hdr_ready   = !route_active && (sel_udp ? udp_hdr_ready : ip_hdr_ready);

  assign udp_beat       = s_beat;
  assign ip_beat        = s_beat;
  assign udp_beat_valid = s_beat_valid && route_active && route_udp;
  assign ip_beat_valid  = s_beat_valid && route_active && !route_udp;
  assign s_beat_ready   = route_active && (route_udp ? udp_beat_ready : ip_beat_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      route_active <= 1'b0;
      route_udp    <= 1'b0;
    end else if (!route_active) begin
      if (s_hdr_valid && s_hdr_ready) begin
        route_active <= 1'b1;
        route_udp    <= sel_udp;
      end
    end else if (s_beat_valid && s_beat_ready && s_beat.last) begin
      route_active <= 1'b0;
    end
  end

endmodule

// ==== hw/udp_switch_pkg.sv ====
/* Shared widths, constants and channel structs for the protocol switch.
   Lane 0 of data/keep is the first byte on the wire. State names carry
   RX_/TX_ prefixes because both FSM enums share this package scope. */
package udp_switch_pkg;

  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] port_t;
  typedef logic [15:0] len16_t;

  localparam logic [7:0] PROTO_UDP     = 8'd17;
  localparam len16_t     IP_HDR_BYTES  = 16'd20;
  localparam int         UDP_HDR_BYTES = 8;

  // 104 bits
  typedef struct packed {
    logic [5:0] dscp;
    logic [1:0] ecn;
    len16_t     length;
    logic [7:0] ttl;
    logic [7:0] protocol;
    ip_addr_t   source_ip;
    ip_addr_t   dest_ip;
  } ip_hdr_t;

  // 144 bits, IP fields first
  typedef struct packed {
    logic [5:0] ip_dscp;
    logic [1:0] ip_ecn;
    logic [7:0] ip_ttl;
    ip_addr_t   ip_source_ip;
    ip_addr_t   ip_dest_ip;
    port_t      source_port;
    port_t      dest_port;
    len16_t     length;
    len16_t     checksum;
  } udp_hdr_t;

  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
    logic  user;
  } axis_beat_t;

  typedef enum logic [1:0] {TX_IDLE, TX_HDR_BEAT, TX_PAYLOAD} tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_WAIT_BEAT, RX_HDR_OUT, RX_PAYLOAD} rx_state_t;

endpackage
